// File: axis_frame_cdc_pkg.sv
package axis_frame_cdc_pkg;

    // beat geometry
    localparam int DATA_WIDTH = 64;
    localparam int KEEP_WIDTH = DATA_WIDTH / 8;

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [KEEP_WIDTH-1:0] keep_t;

    // one stream beat, also the RAM word
    typedef struct packed {
        data_t data;
        keep_t keep;
        logic  last;
    } axis_beat_t;

    // single-cycle frame event flags
    typedef struct packed {
        logic overflow;
        logic bad_frame;
        logic good_frame;
    } frame_status_t;

    // write side frame handling
    typedef enum logic {
        WR_STORE,
        WR_DROP
    } frame_wr_state_t;

endpackage

// File: cdc_reset_sync.sv
`timescale 1ns/10ps

module cdc_reset_sync (
    input  logic async_rst,
    input  logic input_clk,
    input  logic output_clk,
    output logic wr_rst,
    output logic rd_rst
);

    logic in_rst_sync1;
    logic in_rst_sync2;
    logic out_rst_sync1;
    logic out_rst_sync2;

    // input domain chain
    // second stage also waits for the output domain's first stage
    always_ff @(posedge input_clk or posedge async_rst) begin
        if (async_rst) begin
            in_rst_sync1 <= 1'b1;
            in_rst_sync2 <= 1'b1;
            wr_rst       <= 1'b1;
        end else begin
            in_rst_sync1 <= 1'b0;
            in_rst_sync2 <= in_rst_sync1 | out_rst_sync1;
            wr_rst       <= in_rst_sync2;
        end
    end

    // output domain chain, mirror of the above
    always_ff @(posedge output_clk or posedge async_rst) begin
        if (async_rst) begin
            out_rst_sync1 <= 1'b1;
            out_rst_sync2 <= 1'b1;
            rd_rst        <= 1'b1;
        end else begin
            out_rst_sync1 <= 1'b0;
            out_rst_sync2 <= in_rst_sync1 | out_rst_sync1;
            rd_rst        <= out_rst_sync2;
        end
    end

endmodule

// File: frame_fifo_ram.sv
`timescale 1ns/10ps

module frame_fifo_ram #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                           input_clk,
    input  logic                           wr_en,
    input  logic [ADDR_WIDTH-1:0]          wr_addr,
    input  axis_frame_cdc_pkg::axis_beat_t wr_beat,
    input  logic                           output_clk,
    input  logic                           rd_en,
    input  logic [ADDR_WIDTH-1:0]          rd_addr,
    output axis_frame_cdc_pkg::axis_beat_t rd_beat
);

    import axis_frame_cdc_pkg::*;

    axis_beat_t mem [0:(2**ADDR_WIDTH)-1];

    // write port, input domain
    always_ff @(posedge input_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_beat;
        end
    end

    // registered read port, output domain
    always_ff @(posedge output_clk) begin
        if (rd_en) begin
            rd_beat <= mem[rd_addr];
        end
    end

endmodule

// File: frame_fifo_wr.sv
`timescale 1ns/10ps

module frame_fifo_wr #(
    parameter int ADDR_WIDTH     = 12,
    parameter bit DROP_WHEN_FULL = 1'b0
) (
    input  logic                              input_clk,
    input  logic                              wr_rst,
    input  axis_frame_cdc_pkg::axis_beat_t    ingress_beat,
    input  logic                              ingress_valid,
    input  logic                              ingress_user,
    output logic                              ingress_ready,
    input  logic [ADDR_WIDTH:0]               rd_ptr_gray,
    output logic [ADDR_WIDTH:0]               wr_ptr_gray,
    output logic                              wr_en,
    output logic [ADDR_WIDTH-1:0]             wr_addr,
    output axis_frame_cdc_pkg::axis_beat_t    wr_beat,
    output axis_frame_cdc_pkg::frame_status_t ingress_status
);

    import axis_frame_cdc_pkg::*;

    typedef logic [ADDR_WIDTH:0] ptr_t;

    // committed end of the last good frame, and write position in the open frame
    ptr_t wr_ptr_commit;
    ptr_t wr_ptr_cur;
    ptr_t ptr_inc;
    ptr_t cur_gray;

    ptr_t rd_ptr_gray_sync1;
    ptr_t rd_ptr_gray_sync2;

    frame_wr_state_t wr_state;

    logic wr_open;
    logic full;
    logic full_cur;
    logic accept;
    logic drop_beat;

    assign ptr_inc  = wr_ptr_cur + 1'b1;
    assign cur_gray = wr_ptr_cur ^ (wr_ptr_cur >> 1);

    // current position one whole RAM ahead of the reader
    // Gray form: top two bits inverted, rest equal
    assign full = (cur_gray == {~rd_ptr_gray_sync2[ADDR_WIDTH:ADDR_WIDTH-1],
                                rd_ptr_gray_sync2[ADDR_WIDTH-2:0]});

    // open frame has wrapped onto its own start
    assign full_cur = (wr_ptr_cur[ADDR_WIDTH] != wr_ptr_commit[ADDR_WIDTH]) &&
                      (wr_ptr_cur[ADDR_WIDTH-1:0] == wr_ptr_commit[ADDR_WIDTH-1:0]);

    // keep accepting while a frame is being thrown away
    assign ingress_ready = wr_open &&
                           (!full || DROP_WHEN_FULL || full_cur || (wr_state == WR_DROP));

    assign accept    = ingress_valid && ingress_ready;
    assign drop_beat = full || full_cur || (wr_state == WR_DROP);

    // RAM write straight from the accepted beat
    assign wr_en   = accept && !drop_beat;
    assign wr_addr = wr_ptr_cur[ADDR_WIDTH-1:0];
    assign wr_beat = ingress_beat;

    // read pointer into the input domain
    always_ff @(posedge input_clk or posedge wr_rst) begin
        if (wr_rst) begin
            rd_ptr_gray_sync1 <= '0;
            rd_ptr_gray_sync2 <= '0;
        end else begin
            rd_ptr_gray_sync1 <= rd_ptr_gray;
            rd_ptr_gray_sync2 <= rd_ptr_gray_sync1;
        end
    end

    always_ff @(posedge input_clk or posedge wr_rst) begin
        if (wr_rst) begin
            wr_open        <= 1'b0;
            wr_state       <= WR_STORE;
            wr_ptr_commit  <= '0;
            wr_ptr_cur     <= '0;
            wr_ptr_gray    <= '0;
            ingress_status <= '0;
        end else begin
            wr_open        <= 1'b1;
            ingress_status <= '0;
            if (accept) begin
                if (drop_beat) begin
                    if (ingress_beat.last) begin
                        // rewind over whatever was stored
                        wr_ptr_cur              <= wr_ptr_commit;
                        wr_state                <= WR_STORE;
                        ingress_status.overflow <= 1'b1;
                    end else begin
                        wr_state <= WR_DROP;
                    end
                end else if (ingress_beat.last) begin
                    if (ingress_user) begin
                        wr_ptr_cur               <= wr_ptr_commit;
                        ingress_status.bad_frame <= 1'b1;
                    end else begin
                        // commit, and make the frame visible to the reader
                        wr_ptr_cur                <= ptr_inc;
                        wr_ptr_commit             <= ptr_inc;
                        wr_ptr_gray               <= ptr_inc ^ (ptr_inc >> 1);
                        ingress_status.good_frame <= 1'b1;
                    end
                end else begin
                    wr_ptr_cur <= ptr_inc;
                end
            end
        end
    end

endmodule

// File: frame_fifo_rd.sv
`timescale 1ns/10ps

module frame_fifo_rd #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                           output_clk,
    input  logic                           rd_rst,
    input  logic [ADDR_WIDTH:0]            wr_ptr_gray,
    output logic [ADDR_WIDTH:0]            rd_ptr_gray,
    output logic                           rd_en,
    output logic [ADDR_WIDTH-1:0]          rd_addr,
    input  axis_frame_cdc_pkg::axis_beat_t rd_beat,
    output axis_frame_cdc_pkg::axis_beat_t egress_beat,
    output logic                           egress_valid,
    input  logic                           egress_ready
);

    typedef logic [ADDR_WIDTH:0] ptr_t;

    ptr_t rd_ptr;
    ptr_t rd_ptr_inc;
    ptr_t wr_ptr_gray_sync1;
    ptr_t wr_ptr_gray_sync2;

    // valid of the RAM read register
    logic ram_valid;
    logic ram_advance;
    logic store_output;
    logic empty;

    // only committed frames are visible here
    assign empty = (rd_ptr_gray == wr_ptr_gray_sync2);

    // output register free, or its beat leaves this cycle
    assign store_output = egress_ready || !egress_valid;

    // RAM stage can take a new beat when empty or handing over
    assign ram_advance = store_output || !ram_valid;

    assign rd_en      = ram_advance && !empty;
    assign rd_addr    = rd_ptr[ADDR_WIDTH-1:0];
    assign rd_ptr_inc = rd_ptr + 1'b1;

    // write pointer into the output domain
    always_ff @(posedge output_clk or posedge rd_rst) begin
        if (rd_rst) begin
            wr_ptr_gray_sync1 <= '0;
            wr_ptr_gray_sync2 <= '0;
        end else begin
            wr_ptr_gray_sync1 <= wr_ptr_gray;
            wr_ptr_gray_sync2 <= wr_ptr_gray_sync1;
        end
    end

    always_ff @(posedge output_clk or posedge rd_rst) begin
        if (rd_rst) begin
            rd_ptr       <= '0;
            rd_ptr_gray  <= '0;
            ram_valid    <= 1'b0;
            egress_valid <= 1'b0;
        end else begin
            if (rd_en) begin
                rd_ptr      <= rd_ptr_inc;
                rd_ptr_gray <= rd_ptr_inc ^ (rd_ptr_inc >> 1);
            end
            if (ram_advance) begin
                ram_valid <= !empty;
            end
            if (store_output) begin
                egress_valid <= ram_valid;
            end
        end
    end

    // output payload, held while stalled
    always_ff @(posedge output_clk) begin
        if (store_output && ram_valid) begin
            egress_beat <= rd_beat;
        end
    end

endmodule

// File: status_pulse_sync.sv
`timescale 1ns/10ps

module status_pulse_sync (
    input  logic                              input_clk,
    input  logic                              output_clk,
    input  logic                              wr_rst,
    input  logic                              rd_rst,
    input  axis_frame_cdc_pkg::frame_status_t ingress_status,
    output axis_frame_cdc_pkg::frame_status_t egress_status
);

    import axis_frame_cdc_pkg::*;

    // one toggle bit per event
    frame_status_t status_toggle;

    frame_status_t status_sync1;
    frame_status_t status_sync2;
    frame_status_t status_sync3;

    always_ff @(posedge input_clk or posedge wr_rst) begin
        if (wr_rst) begin
            status_toggle <= '0;
        end else begin
            status_toggle <= status_toggle ^ ingress_status;
        end
    end

    // sync1/sync2 resolve metastability, sync3 holds the previous level
    always_ff @(posedge output_clk or posedge rd_rst) begin
        if (rd_rst) begin
            status_sync1 <= '0;
            status_sync2 <= '0;
            status_sync3 <= '0;
        end else begin
            status_sync1 <= status_toggle;
            status_sync2 <= status_sync1;
            status_sync3 <= status_sync2;
        end
    end

    // level change becomes a one-cycle pulse
    assign egress_status = frame_status_t'(status_sync2 ^ status_sync3);

endmodule

// File: axis_frame_cdc.sv
`timescale 1ns/10ps

module axis_frame_cdc #(
    parameter int ADDR_WIDTH     = 12,
    parameter bit DROP_WHEN_FULL = 1'b0
) (
    input  logic                              async_rst,
    input  logic                              input_clk,
    input  logic                              output_clk,

    // ingress stream, input_clk
    input  axis_frame_cdc_pkg::axis_beat_t    ingress_beat,
    input  logic                              ingress_valid,
    input  logic                              ingress_user,
    output logic                              ingress_ready,

    // egress stream, output_clk
    output axis_frame_cdc_pkg::axis_beat_t    egress_beat,
    output logic                              egress_valid,
    input  logic                              egress_ready,

    // frame events in both domains
    output axis_frame_cdc_pkg::frame_status_t ingress_status,
    output axis_frame_cdc_pkg::frame_status_t egress_status
);

    import axis_frame_cdc_pkg::*;

    logic wr_rst;
    logic rd_rst;

    logic                  wr_en;
    logic [ADDR_WIDTH-1:0] wr_addr;
    axis_beat_t            wr_beat;
    logic                  rd_en;
    logic [ADDR_WIDTH-1:0] rd_addr;
    axis_beat_t            rd_beat;

    // Gray pointers crossing between the domains
    logic [ADDR_WIDTH:0] wr_ptr_gray;
    logic [ADDR_WIDTH:0] rd_ptr_gray;

    cdc_reset_sync u_reset_sync (
        .async_rst  (async_rst),
        .input_clk  (input_clk),
        .output_clk (output_clk),
        .wr_rst     (wr_rst),
        .rd_rst     (rd_rst)
    );

    frame_fifo_ram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_ram (
        .input_clk  (input_clk),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_beat    (wr_beat),
        .output_clk (output_clk),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_beat    (rd_beat)
    );

    frame_fifo_wr #(
        .ADDR_WIDTH     (ADDR_WIDTH),
        .DROP_WHEN_FULL (DROP_WHEN_FULL)
    ) u_wr (
        .input_clk      (input_clk),
        .wr_rst         (wr_rst),
        .ingress_beat   (ingress_beat),
        .ingress_valid  (ingress_valid),
        .ingress_user   (ingress_user),
        .ingress_ready  (ingress_ready),
        .rd_ptr_gray    (rd_ptr_gray),
        .wr_ptr_gray    (wr_ptr_gray),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_beat        (wr_beat),
        .ingress_status (ingress_status)
    );

    frame_fifo_rd #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_rd (
        .output_clk   (output_clk),
        .rd_rst       (rd_rst),
        .wr_ptr_gray  (wr_ptr_gray),
        .rd_ptr_gray  (rd_ptr_gray),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .rd_beat      (rd_beat),
        .egress_beat  (egress_beat),
        .egress_valid (egress_valid),
        .egress_ready (egress_ready)
    );

    status_pulse_sync u_status_sync (
        .input_clk      (input_clk),
        .output_clk     (output_clk),
        .wr_rst         (wr_rst),
        .rd_rst         (rd_rst),
        .ingress_status (ingress_status),
        .egress_status  (egress_status)
    );

endmodule

// File: axis_frame_cdc_assertions.sv
`timescale 1ns/10ps

module axis_frame_cdc_assertions (
    input logic                                input_clk,
    input logic                                wr_rst,
    input logic                                wr_en,
    input axis_frame_cdc_pkg::frame_wr_state_t wr_state,
    input logic                                output_clk,
    input logic                                rd_rst,
    input axis_frame_cdc_pkg::axis_beat_t      egress_beat,
    input logic                                egress_valid,
    input logic                                egress_ready
);

    import axis_frame_cdc_pkg::*;

    // RAM untouched while the write side is in reset
    no_write_in_reset: assert property (@(posedge input_clk) wr_rst |-> !wr_en)
        else $error("RAM write while wr_rst is high");

    no_write_when_dropping: assert property (
        @(posedge input_clk) disable iff (wr_rst) (wr_state == WR_DROP) |-> !wr_en)
        else $error("RAM write in WR_DROP");

    // stalled egress beat holds until it transfers
    egress_hold: assert property (
        @(posedge output_clk) disable iff (rd_rst)
        (egress_valid && !egress_ready) |=> (egress_valid && $stable(egress_beat)))
        else $error("egress beat changed while egress_ready was low");

endmodule

bind frame_fifo_wr axis_frame_cdc_assertions u_wr_checks (
    .input_clk    (input_clk),
    .wr_rst       (wr_rst),
    .wr_en        (wr_en),
    .wr_state     (wr_state),
    .output_clk   (1'b0),
    .rd_rst       (1'b1),
    .egress_beat  ('0),
    .egress_valid (1'b0),
    .egress_ready (1'b0)
);

bind frame_fifo_rd axis_frame_cdc_assertions u_rd_checks (
    .input_clk    (1'b0),
    .wr_rst       (1'b1),
    .wr_en        (1'b0),
    .wr_state     (axis_frame_cdc_pkg::WR_STORE),
    .output_clk   (output_clk),
    .rd_rst       (rd_rst),
    .egress_beat  (egress_beat),
    .egress_valid (egress_valid),
    .egress_ready (egress_ready)
);

// File: tb_axis_frame_cdc.sv
`timescale 1ns/10ps

module tb_axis_frame_cdc;

    import axis_frame_cdc_pkg::*;

    localparam int ADDR_WIDTH   = 5;
    localparam int DEPTH        = 2 ** ADDR_WIDTH;
    localparam int FATE_GOOD    = 0;
    localparam int FATE_BAD     = 1;
    localparam int FATE_OVF     = 2;
    localparam int READY_RANDOM = 0;
    localparam int READY_LOW    = 1;
    localparam int READY_HIGH   = 2;

    logic          async_rst;
    logic          input_clk;
    logic          output_clk;
    axis_beat_t    ingress_beat;
    logic          ingress_valid;
    logic          ingress_user;
    logic          ingress_ready;
    axis_beat_t    egress_beat;
    logic          egress_valid;
    logic          egress_ready;
    frame_status_t ingress_status;
    frame_status_t egress_status;

    logic [15:0] lfsr_state  = 16'd45411;
    int          ready_mode  = READY_HIGH;
    bit          stall_seen  = 1'b0;
    int          beats_sent  = 0;
    int          error_count = 0;
    int          check_count = 0;

    // indexed by frame fate as good, bad and overflow
    int exp_count [3] = '{0, 0, 0};
    int in_count  [3] = '{0, 0, 0};
    int out_count [3] = '{0, 0, 0};

    axis_beat_t expected_beats [$];

    axis_frame_cdc #(
        .ADDR_WIDTH     (ADDR_WIDTH),
        .DROP_WHEN_FULL (1'b0)
    ) DUT (
        .*
    );

    initial begin
        input_clk = 1'b0;
        forever #15 input_clk = ~input_clk;
    end

    // offset so no output edge meets an input falling edge
    initial begin
        output_clk = 1'b0;
        #5;
        forever #20 output_clk = ~output_clk;
    end

    initial begin
        async_rst     = 1'b0;
        ingress_beat  = '0;
        ingress_valid = 1'b0;
        ingress_user  = 1'b0;
        #1;
        async_rst = 1'b1;
        repeat (8) @(posedge output_clk);
        #2;
        async_rst = 1'b0;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    // one LFSR step per bit taken
    function automatic logic [63:0] rand_bits(input int count);
        logic [63:0] value;
        int          i;
        value = '0;
        for (i = 0; i < count; i++) begin
            value      = {value[62:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    // expected fate of a frame sent into a drained FIFO
    // too long for the RAM wins over the bad mark
    function automatic int frame_fate(input int len, input bit bad);
        if (len > DEPTH) begin
            return FATE_OVF;
        end
        return bad ? FATE_BAD : FATE_GOOD;
    endfunction

    // every predicted event has shown up at egress
    function automatic bit egress_counts_done();
        return out_count[FATE_GOOD] == exp_count[FATE_GOOD] &&
               out_count[FATE_BAD] == exp_count[FATE_BAD] &&
               out_count[FATE_OVF] == exp_count[FATE_OVF];
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        check_count++;
        assert (got === expected)
        else begin
            $display("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, expected);
            error_count++;
        end
    endtask

    task automatic send_frame(input int len, input bit bad);
        axis_beat_t beats [$];
        axis_beat_t beat;
        int         fate;
        int         i;
        for (i = 0; i < len; i++) begin
            beat.data = rand_bits(DATA_WIDTH);
            beat.keep = keep_t'(rand_bits(KEEP_WIDTH));
            beat.last = (i == len - 1);
            beats.push_back(beat);
        end
        fate = frame_fate(len, bad);
        exp_count[fate]++;
        if (fate == FATE_GOOD) begin
            foreach (beats[j]) begin
                expected_beats.push_back(beats[j]);
            end
        end
        @(posedge input_clk);
        #2;
        for (i = 0; i < len; i++) begin
            ingress_beat  = beats[i];
            ingress_valid = 1'b1;
            ingress_user  = bad && beats[i].last;
            @(negedge input_clk);
            while (ingress_ready !== 1'b1) begin
                stall_seen = 1'b1;
                @(negedge input_clk);
            end
            @(posedge input_clk);
            #2;
            beats_sent++;
        end
        ingress_valid = 1'b0;
        ingress_user  = 1'b0;
    endtask

    // empty model queue and all event pulses seen on the egress side
    task automatic wait_drained();
        int cycles;
        cycles = 0;
        while ((expected_beats.size() != 0 || !egress_counts_done()) && cycles < 1000) begin
            @(negedge output_clk);
            cycles++;
        end
        assert (cycles < 1000)
        else begin
            $display("ERROR at %0d ns: FIFO did not drain, %0d beats still expected",
                     $time, expected_beats.size());
            error_count++;
        end
        repeat (10) @(negedge output_clk);
        check_value("ingress_status.good_frame count", in_count[FATE_GOOD], exp_count[FATE_GOOD]);
        check_value("ingress_status.bad_frame count", in_count[FATE_BAD], exp_count[FATE_BAD]);
        check_value("ingress_status.overflow count", in_count[FATE_OVF], exp_count[FATE_OVF]);
        check_value("egress_status.good_frame count", out_count[FATE_GOOD], exp_count[FATE_GOOD]);
        check_value("egress_status.bad_frame count", out_count[FATE_BAD], exp_count[FATE_BAD]);
        check_value("egress_status.overflow count", out_count[FATE_OVF], exp_count[FATE_OVF]);
    endtask

    task automatic report_test(input int num, input string name, input int start_errors);
        if (error_count == start_errors) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, error_count - start_errors);
        end
    endtask

    // sink ready with random stalls about one cycle in four
    initial begin : drive_egress_ready
        logic [1:0] ready_bits;
        egress_ready = 1'b0;
        forever begin
            // drawn on the edge, driven just after it
            @(posedge output_clk);
            if (ready_mode == READY_RANDOM) begin
                ready_bits = 2'(rand_bits(2));
            end else if (ready_mode == READY_HIGH) begin
                ready_bits = 2'b11;
            end else begin
                ready_bits = 2'b00;
            end
            #2;
            egress_ready = |ready_bits;
        end
    end

    initial begin
        forever begin
            @(negedge input_clk);
            if (ingress_status.good_frame === 1'b1) in_count[FATE_GOOD]++;
            if (ingress_status.bad_frame === 1'b1) in_count[FATE_BAD]++;
            if (ingress_status.overflow === 1'b1) in_count[FATE_OVF]++;
        end
    end

    // egress beats against the model queue
    initial begin : compare_egress
        axis_beat_t exp_beat;
        forever begin
            @(negedge output_clk);
            if (egress_valid === 1'b1 && egress_ready === 1'b1) begin
                assert (expected_beats.size() != 0)
                else begin
                    $display("ERROR at %0d ns: egress beat arrived with none expected", $time);
                    error_count++;
                end
                if (expected_beats.size() != 0) begin
                    exp_beat = expected_beats.pop_front();
                    check_value("egress_beat.data", egress_beat.data, exp_beat.data);
                    check_value("egress_beat.keep", egress_beat.keep, exp_beat.keep);
                    check_value("egress_beat.last", egress_beat.last, exp_beat.last);
                end
            end
            if (egress_status.good_frame === 1'b1) out_count[FATE_GOOD]++;
            if (egress_status.bad_frame === 1'b1) out_count[FATE_BAD]++;
            if (egress_status.overflow === 1'b1) out_count[FATE_OVF]++;
        end
    end

    // deadline grows with every beat sent
    initial begin
        while ($time <= 64'd20000 + 64'd200 * beats_sent) begin
            #1000;
        end
        $display("watchdog: run stalled at %0d ns after %0d beats", $time, beats_sent);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : main
        int start_errors;
        int n;
        int cycles;

        // outputs quiet through reset
        start_errors = error_count;
        wait (async_rst === 1'b1);
        while (async_rst === 1'b1) begin
            @(negedge input_clk);
            check_value("ingress_ready", ingress_ready, 0);
            check_value("egress_valid", egress_valid, 0);
            check_value("egress_status", egress_status, 0);
            check_value("ingress_status", ingress_status, 0);
        end
        cycles = 0;
        while (ingress_ready !== 1'b1 && cycles < 50) begin
            check_value("egress_valid", egress_valid, 0);
            check_value("egress_status", egress_status, 0);
            check_value("ingress_status", ingress_status, 0);
            @(negedge input_clk);
            cycles++;
        end
        assert (ingress_ready === 1'b1)
        else begin
            $display("ERROR at %0d ns: ingress_ready did not rise after reset", $time);
            error_count++;
        end
        report_test(1, "reset", start_errors);

        // good frames with a stalling sink
        start_errors = error_count;
        ready_mode   = READY_RANDOM;
        for (n = 0; n < 20; n++) begin
            send_frame(1 + int'(rand_bits(5)), 1'b0);
        end
        wait_drained();
        report_test(2, "good frames", start_errors);

        // bad frames between good ones
        start_errors = error_count;
        for (n = 0; n < 4; n++) begin
            send_frame(1 + int'(rand_bits(5)), 1'b1);
            send_frame(1 + int'(rand_bits(5)), 1'b0);
        end
        wait_drained();
        report_test(3, "bad frames", start_errors);

        // frame longer than the RAM, then a good one
        start_errors = error_count;
        send_frame(36, 1'b0);
        send_frame(1 + int'(rand_bits(5)), 1'b0);
        wait_drained();
        report_test(4, "oversize frame", start_errors);

        // sink held off until the FIFO pushes back
        start_errors = error_count;
        stall_seen   = 1'b0;
        ready_mode   = READY_LOW;
        fork
            begin
                n = 0;
                while (!stall_seen && n < 16) begin
                    send_frame(4, 1'b0);
                    n++;
                end
            end
            begin
                cycles = 0;
                while (!stall_seen && cycles < 1000) begin
                    @(negedge input_clk);
                    cycles++;
                end
                assert (stall_seen)
                else begin
                    $display("ERROR at %0d ns: ingress_ready stayed high with the sink held off",
                             $time);
                    error_count++;
                end
                repeat (20) @(posedge output_clk);
                #2;
                ready_mode = READY_RANDOM;
            end
        join
        wait_drained();
        report_test(5, "back-pressure", start_errors);

        $display("summary: %0d checks, %0d errors, %0d beats sent",
                 check_count, error_count, beats_sent);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: axis_frame_cdc.f
axis_frame_cdc_pkg.sv
cdc_reset_sync.sv
frame_fifo_ram.sv
frame_fifo_wr.sv
frame_fifo_rd.sv
status_pulse_sync.sv
axis_frame_cdc.sv
axis_frame_cdc_assertions.sv
tb_axis_frame_cdc.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_axis_frame_cdc
FILELIST = axis_frame_cdc.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "=== FAIL ===" $(LOG) || \
	   ! grep -q "=== PASS ===" $(LOG); then \
	    echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
